// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - files:
      - design/fetch_pkg.sv
      - design/prefetch.sv
      - design/prefetch_control.sv
      - design/code_tlb.sv
      - design/code_reader.sv
      - design/prefetch_fifo.sv
      - design/fetch_unit.sv
  - target: test
    files:
      - bench/fetch_unit_tb.sv

// ==== bench/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb;
    import fetch_pkg::*;

    logic                           clk;
    logic                           rst;
    logic                           branch_do;
    logic [31:0]                    branch_address;
    logic                           branch_su;
    logic [31:0]                    fetch_limit;
    logic                           tlb_write;
    logic [$clog2(TLB_ENTRIES)-1:0] tlb_index;
    logic [PAGE_BITS-1:0]           tlb_linear_page;
    logic [PAGE_BITS-1:0]           tlb_physical_page;
    logic                           tlb_user;
    logic                           fifo_pop;
    logic                           fifo_valid;
    logic [31:0]                    fifo_data;
    logic [2:0]                     fifo_bytes;
    logic                           code_fault;
    logic [31:0]                    araddr;
    logic                           arvalid;
    logic                           arready;
    logic [31:0]                    rdata;
    logic [1:0]                     rresp;
    logic                           rvalid;
    logic                           rready;

    // Copy of the TLB contents
    logic [TLB_ENTRIES-1:0] ref_valid;
    logic [PAGE_BITS-1:0]   ref_lin  [TLB_ENTRIES];
    logic [PAGE_BITS-1:0]   ref_phys [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] ref_user;

    // Decoder model state, owned by the pop process
    logic [31:0] exp_addr;
    logic [31:0] exp_limit;
    logic        exp_su;
    int          since_branch;
    // Address phase hold tracking
    logic        held_ar = 1'b0;
    logic [31:0] held_addr;
    int unsigned seed_value;

    fetch_unit DUT (.*);

    always #50 clk = ~clk;

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------
    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic event_error(input string what);
        $display("At %0t: %s", $time, what);
        abort_run();
    endtask

    // All address bytes folded in, so pages differ
    function automatic logic [7:0] mem_byte(input logic [31:0] pa);
        return pa[7:0] ^ pa[15:8] ^ pa[23:16] ^ pa[31:24] ^ 8'h5A;
    endfunction

    // Expected byte at a linear address through the TLB copy
    task automatic check_byte(input logic [31:0] lin, input logic [7:0] got);
        logic [31:0] pa;
        logic        found;
        logic        allowed;
        found   = 1'b0;
        allowed = 1'b0;
        pa      = '0;
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            if (ref_valid[k] && ref_lin[k] == lin[31:12]) begin
                found   = 1'b1;
                allowed = exp_su || ref_user[k];
                pa      = {ref_phys[k], lin[11:0]};
            end
        end
        if (!found) begin
            event_error($sformatf("byte popped from unmapped linear address %h", lin));
        end else if (!allowed) begin
            event_error($sformatf("user fetch delivered supervisor byte at %h", lin));
        end else begin
            assert (got == mem_byte(pa))
                else value_error($sformatf("fifo_data byte at %h", lin), mem_byte(pa), got);
        end
    endtask

    // ----------------------------------------
    // AXI memory with random delays
    // ----------------------------------------
    always begin : axi_memory
        int unsigned delay;
        int          cycles;
        logic [31:0] word_addr;
        @(posedge clk);
        if (!rst && arvalid) begin
            delay = $urandom_range(3);
            repeat (delay) @(posedge clk);
            arready <= 1'b1;
            // Handshake lands on this edge
            @(posedge clk);
            word_addr = araddr;
            arready <= 1'b0;
            delay = $urandom_range(3);
            repeat (delay) @(posedge clk);
            rdata  <= {mem_byte(word_addr + 32'd3), mem_byte(word_addr + 32'd2),
                       mem_byte(word_addr + 32'd1), mem_byte(word_addr)};
            rvalid <= 1'b1;
            @(posedge clk);
            cycles = 0;
            while (!rready && cycles < 1000) begin
                @(posedge clk);
                cycles++;
            end
            if (!rready) begin
                event_error("Timeout waiting for rready on a read beat");
            end
            rvalid <= 1'b0;
        end
    end

    // ----------------------------------------
    // Decoder with random pops and byte checks
    // ----------------------------------------
    always @(posedge clk) begin : decoder_model
        logic [31:0] lin;
        if (rst) begin
            since_branch = 0;
            fifo_pop <= 1'b0;
        end else begin
            if (branch_do) begin
                // Queue flushes on this edge, a pop here is void
                exp_addr     = branch_address;
                exp_limit    = fetch_limit;
                exp_su       = branch_su;
                since_branch = 0;
            end else if (fifo_pop && fifo_valid) begin
                if (fifo_bytes == 3'd0 || fifo_bytes > 3'd4) begin
                    event_error($sformatf("fifo_bytes is %0d, outside 1 to 4", fifo_bytes));
                end
                for (int i = 0; i < 4; i++) begin
                    if (i < fifo_bytes) begin
                        lin = exp_addr + i;
                        assert (lin <= exp_limit)
                            else value_error("linear address vs fetch_limit", exp_limit, lin);
                        check_byte(lin, fifo_data[8*i +: 8]);
                    end
                end
                exp_addr     = exp_addr + fifo_bytes;
                since_branch = since_branch + fifo_bytes;
            end
            // Slow decoder, lets the queue fill up
            fifo_pop <= ($urandom_range(2) == 0);
        end
    end

    // AXI address rules
    ar_aligned: assert property (@(posedge clk) disable iff (rst) arvalid |-> araddr[1:0] == 2'b00)
        else value_error("araddr[1:0]", 32'd0, {30'd0, $sampled(araddr[1:0])});

    always @(posedge clk) begin
        if (!rst && held_ar) begin
            assert (arvalid) else value_error("arvalid", 32'd1, {31'd0, arvalid});
            assert (araddr == held_addr) else value_error("araddr", held_addr, araddr);
        end
        held_ar   <= !rst && arvalid && !arready;
        held_addr <= araddr;
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic load_entry(input int idx, input logic [PAGE_BITS-1:0] lin_page,
                              input logic [PAGE_BITS-1:0] phys_page, input logic usr);
        ref_valid[idx] = 1'b1;
        ref_lin[idx]   = lin_page;
        ref_phys[idx]  = phys_page;
        ref_user[idx]  = usr;
        @(posedge clk);
        tlb_write         <= 1'b1;
        tlb_index         <= idx[2:0];
        tlb_linear_page   <= lin_page;
        tlb_physical_page <= phys_page;
        tlb_user          <= usr;
        @(posedge clk);
        tlb_write <= 1'b0;
    endtask

    task automatic branch_to(input logic [31:0] addr, input logic [31:0] limit,
                             input logic su);
        @(posedge clk);
        branch_do      <= 1'b1;
        branch_address <= addr;
        fetch_limit    <= limit;
        branch_su      <= su;
        @(posedge clk);
        branch_do <= 1'b0;
    endtask

    task automatic wait_bytes(input int count, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (since_branch < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (since_branch < count) begin
            event_error($sformatf("Timeout after %0d of %0d bytes", since_branch, count));
        end
    endtask

    task automatic wait_fault(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!code_fault && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!code_fault) begin
            event_error("Timeout waiting for code_fault");
        end
    endtask

    // Quiet window, fifo_valid must never rise
    task automatic expect_silence(input int limit);
        int cycles;
        cycles = 0;
        while (cycles < limit) begin
            @(negedge clk);
            assert (!fifo_valid) else value_error("fifo_valid", 32'd0, {31'd0, fifo_valid});
            cycles++;
        end
    endtask

    task automatic wait_read_pending(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(arvalid || rready) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!(arvalid || rready)) begin
            event_error("Timeout waiting for an outstanding AXI read");
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        seed_value        = $urandom(26);
        clk               = 1'b0;
        rst               = 1'b1;
        branch_do         = 1'b0;
        branch_address    = '0;
        branch_su         = 1'b0;
        fetch_limit       = '0;
        tlb_write         = 1'b0;
        tlb_index         = '0;
        tlb_linear_page   = '0;
        tlb_physical_page = '0;
        tlb_user          = 1'b0;
        fifo_pop          = 1'b0;
        arready           = 1'b0;
        rdata             = '0;
        rresp             = 2'b00;
        rvalid            = 1'b0;
        ref_valid         = '0;
        ref_user          = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!arvalid) else value_error("arvalid", 32'd0, {31'd0, arvalid});
        assert (!rready) else value_error("rready", 32'd0, {31'd0, rready});
        assert (!fifo_valid) else value_error("fifo_valid", 32'd0, {31'd0, fifo_valid});
        assert (!code_fault) else value_error("code_fault", 32'd0, {31'd0, code_fault});

        // Adjacent linear pages on scattered physical pages
        load_entry(0, 20'h00010, 20'h00123, 1'b1);
        load_entry(1, 20'h00011, 20'h00456, 1'b1);
        // Supervisor only
        load_entry(2, 20'h00020, 20'h00789, 1'b0);

        // Stream across the page boundary 125 bytes in
        branch_to(32'h0001_0F83, 32'hFFFF_FFFF, 1'b0);
        wait_bytes(300, 20000);

        // Branch over reads in flight
        wait_read_pending(2000);
        branch_to(32'h0001_0005, 32'hFFFF_FFFF, 1'b0);
        wait_bytes(40, 5000);

        // 37 bytes up to an inclusive limit
        branch_to(32'h0001_1100, 32'h0001_1124, 1'b0);
        wait_bytes(37, 5000);
        expect_silence(300);
        assert (since_branch == 37) else value_error("bytes up to limit", 32'd37, since_branch);

        // Unmapped page
        branch_to(32'h0003_0000, 32'hFFFF_FFFF, 1'b1);
        wait_fault(200);
        expect_silence(50);
        // User fetch from a supervisor page
        branch_to(32'h0002_0010, 32'hFFFF_FFFF, 1'b0);
        wait_fault(200);
        expect_silence(50);
        assert (since_branch == 0) else value_error("bytes while faulted", 32'd0, since_branch);
        // Same page as supervisor clears the fault
        branch_to(32'h0002_0010, 32'hFFFF_FFFF, 1'b1);
        wait_bytes(20, 5000);
        assert (!code_fault) else value_error("code_fault", 32'd0, {31'd0, code_fault});

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== design/code_reader.sv ====
`timescale 1ns/1ps

module code_reader (
    input  logic        clk,
    input  logic        rst,
    input  logic        pr_reset,
    input  logic        icacheread_do,
    input  logic [31:0] icacheread_address,
    input  logic [4:0]  icacheread_length,
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    output logic        rready,
    output logic        push_do,
    output logic [31:0] push_data,
    output logic [2:0]  push_bytes
);
    import fetch_pkg::*;

    logic [2:0]  state;
    // Branch seen while the address phase was still pending
    logic        aborted;
    // Next byte to fetch and bytes still wanted
    addr_u       cur;
    logic [4:0]  remaining;

    logic [2:0]  avail;
    logic [2:0]  beat_bytes;
    logic [31:0] beat_data;
    logic        last_beat;
    logic        beat;

    // ----------------------------------------
    // AXI read channel
    // ----------------------------------------
    assign araddr  = {cur.flat[31:2], 2'b00};
    assign arvalid = state == RD_ADDR;
    assign rready  = (state == RD_DATA) || (state == RD_DRAIN);
    assign beat    = rvalid && rready;

    // Bytes in this word from the current offset on
    assign avail      = 3'd4 - {1'b0, cur.split.offset[1:0]};
    assign beat_bytes = ({2'b0, avail} > remaining) ? remaining[2:0] : avail;
    // Low byte of the entry is the first wanted byte
    assign beat_data  = rdata >> {cur.split.offset[1:0], 3'b000};
    assign last_beat  = remaining == {2'b0, beat_bytes};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RD_IDLE;
            aborted <= 1'b0;
            push_do <= 1'b0;
        end else begin
            push_do <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (icacheread_do && !pr_reset) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    // arvalid must stay up until the handshake
                    if (arready) begin
                        state   <= (aborted || pr_reset) ? RD_DRAIN : RD_DATA;
                        aborted <= 1'b0;
                    end else if (pr_reset) begin
                        aborted <= 1'b1;
                    end
                end
                RD_DATA: begin
                    if (rvalid && pr_reset) begin
                        state <= RD_IDLE;
                    end else if (rvalid) begin
                        push_do <= 1'b1;
                        state   <= last_beat ? RD_PUSH : RD_ADDR;
                    end else if (pr_reset) begin
                        state <= RD_DRAIN;
                    end
                end
                // Stale beat is thrown away
                RD_DRAIN: begin
                    if (rvalid) begin
                        state <= RD_IDLE;
                    end
                end
                RD_PUSH: begin
                    state <= pr_reset ? RD_IDLE : RD_DONE;
                end
                // Gap so the fetch address settles before the next accept
                RD_DONE: begin
                    state <= RD_IDLE;
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // Request walk and queue entry payload
    always_ff @(posedge clk) begin
        if (state == RD_IDLE && icacheread_do) begin
            cur.flat  <= icacheread_address;
            remaining <= icacheread_length;
        end else if (state == RD_DATA && beat) begin
            cur.flat   <= cur.flat + {29'd0, beat_bytes};
            remaining  <= remaining - {2'b0, beat_bytes};
            push_data  <= beat_data;
            push_bytes <= beat_bytes;
        end
    end

endmodule

// ==== design/code_tlb.sv ====
`timescale 1ns/1ps

module code_tlb (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     pr_reset,
    input  logic                                     tlb_write,
    input  logic [$clog2(fetch_pkg::TLB_ENTRIES)-1:0] tlb_index,
    input  logic [fetch_pkg::PAGE_BITS-1:0]          tlb_linear_page,
    input  logic [fetch_pkg::PAGE_BITS-1:0]          tlb_physical_page,
    input  logic                                     tlb_user,
    input  logic                                     tlbcoderequest_do,
    input  logic [31:0]                              tlbcoderequest_address,
    input  logic                                     tlbcoderequest_su,
    output logic                                     tlbcode_do,
    output logic [31:0]                              tlbcode_linear,
    output logic [31:0]                              tlbcode_physical,
    output logic                                     code_fault
);
    import fetch_pkg::*;

    logic [TLB_ENTRIES-1:0] valid;
    logic [PAGE_BITS-1:0]   lin_page  [TLB_ENTRIES];
    logic [PAGE_BITS-1:0]   phys_page [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] user;

    addr_u                req;
    addr_u                hit_addr;
    logic                 hit;
    logic                 hit_user;
    logic                 allowed;
    logic                 lookup;

    assign req.flat = tlbcoderequest_address;

    // ----------------------------------------
    // Parallel compare
    // ----------------------------------------
    always_comb begin
        hit                   = 1'b0;
        hit_user              = 1'b0;
        hit_addr.split.page   = '0;
        hit_addr.split.offset = req.split.offset;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (valid[i] && lin_page[i] == req.split.page) begin
                hit                 = 1'b1;
                hit_user            = user[i];
                hit_addr.split.page = phys_page[i];
            end
        end
    end

    // User fetches need a user page
    assign allowed = hit && (tlbcoderequest_su || hit_user);
    // One lookup per request, none while answering or faulted
    assign lookup  = tlbcoderequest_do && !pr_reset && !tlbcode_do && !code_fault;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= '0;
            tlbcode_do <= 1'b0;
            code_fault <= 1'b0;
        end else begin
            if (tlb_write) begin
                valid[tlb_index] <= 1'b1;
            end
            tlbcode_do <= lookup && allowed;
            // Fault sticks until the request drops or a branch
            if (pr_reset || !tlbcoderequest_do) begin
                code_fault <= 1'b0;
            end else if (lookup && !allowed) begin
                code_fault <= 1'b1;
            end
        end
    end

    // Entry contents and response payload
    always_ff @(posedge clk) begin
        if (tlb_write) begin
            lin_page[tlb_index]  <= tlb_linear_page;
            phys_page[tlb_index] <= tlb_physical_page;
            user[tlb_index]      <= tlb_user;
        end
        if (lookup) begin
            tlbcode_linear   <= req.flat;
            tlbcode_physical <= hit_addr.flat;
        end
    end

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // ----------------------------------------
    // Address split
    // ----------------------------------------
    localparam int PAGE_BITS   = 20;
    localparam int OFFSET_BITS = 12;

    // One word, seen flat or as page number over byte offset
    typedef union packed {
        logic [31:0] flat;
        struct packed {
            logic [PAGE_BITS-1:0]   page;
            logic [OFFSET_BITS-1:0] offset;
        } split;
    } addr_u;

    // ----------------------------------------
    // Fetch sizing
    // ----------------------------------------
    // Largest single read request in bytes
    localparam int MAX_FETCH_LEN    = 16;
    localparam int FIFO_DEPTH       = 16;
    // Queue levels for throttling the controller
    localparam int FIFO_START_LEVEL = 3;
    localparam int FIFO_STOP_LEVEL  = 8;
    localparam int TLB_ENTRIES      = 8;

    // Controller states
    localparam logic CTRL_TLB  = 1'b0;
    localparam logic CTRL_READ = 1'b1;

    // Reader states
    localparam logic [2:0] RD_IDLE  = 3'd0;
    localparam logic [2:0] RD_ADDR  = 3'd1;
    localparam logic [2:0] RD_DATA  = 3'd2;
    localparam logic [2:0] RD_PUSH  = 3'd3;
    localparam logic [2:0] RD_DONE  = 3'd4;
    localparam logic [2:0] RD_DRAIN = 3'd5;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                     clk,
    input  logic                                     rst,
    // Branch and fetch window
    input  logic                                     branch_do,
    input  logic [31:0]                              branch_address,
    input  logic                                     branch_su,
    input  logic [31:0]                              fetch_limit,
    // TLB load port
    input  logic                                     tlb_write,
    input  logic [$clog2(fetch_pkg::TLB_ENTRIES)-1:0] tlb_index,
    input  logic [fetch_pkg::PAGE_BITS-1:0]          tlb_linear_page,
    input  logic [fetch_pkg::PAGE_BITS-1:0]          tlb_physical_page,
    input  logic                                     tlb_user,
    // Decoder side
    input  logic                                     fifo_pop,
    output logic                                     fifo_valid,
    output logic [31:0]                              fifo_data,
    output logic [2:0]                               fifo_bytes,
    output logic                                     code_fault,
    // AXI4-Lite read master
    output logic [31:0]                              araddr,
    output logic                                     arvalid,
    input  logic                                     arready,
    input  logic [31:0]                              rdata,
    input  logic [1:0]                               rresp,
    input  logic                                     rvalid,
    output logic                                     rready
);
    import fetch_pkg::*;

    logic [31:0] prefetch_address;
    logic [4:0]  prefetch_length;
    logic        prefetch_su;
    logic [$clog2(FIFO_DEPTH):0] prefetchfifo_used;

    logic        tlbcoderequest_do;
    logic [31:0] tlbcoderequest_address;
    logic        tlbcoderequest_su;
    logic        tlbcode_do;
    logic [31:0] tlbcode_linear;
    logic [31:0] tlbcode_physical;

    logic        icacheread_do;
    logic [31:0] icacheread_address;
    logic [4:0]  icacheread_length;

    logic        push_do;
    logic [31:0] push_data;
    logic [2:0]  push_bytes;

    // ----------------------------------------
    // Branch pulse acts as pr_reset everywhere
    // ----------------------------------------
    prefetch u_prefetch (
        .clk, .rst, .pr_reset(branch_do), .branch_address, .fetch_limit, .branch_su,
        .push_do, .push_bytes, .prefetch_address, .prefetch_length, .prefetch_su
    );

    prefetch_control u_prefetch_control (
        .clk, .rst, .pr_reset(branch_do), .prefetch_address, .prefetch_length,
        .prefetch_su, .prefetchfifo_used, .tlbcoderequest_do, .tlbcoderequest_address,
        .tlbcoderequest_su, .tlbcode_do, .tlbcode_linear, .tlbcode_physical,
        .icacheread_do, .icacheread_address, .icacheread_length
    );

    code_tlb u_code_tlb (
        .clk, .rst, .pr_reset(branch_do), .tlb_write, .tlb_index, .tlb_linear_page,
        .tlb_physical_page, .tlb_user, .tlbcoderequest_do, .tlbcoderequest_address,
        .tlbcoderequest_su, .tlbcode_do, .tlbcode_linear, .tlbcode_physical, .code_fault
    );

    // rresp carries no meaning for fetch, beats are taken as data
    code_reader u_code_reader (
        .clk, .rst, .pr_reset(branch_do), .icacheread_do, .icacheread_address,
        .icacheread_length, .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
        .push_do, .push_data, .push_bytes
    );

    prefetch_fifo u_prefetch_fifo (
        .clk, .rst, .pr_reset(branch_do), .push_do, .push_data, .push_bytes,
        .fifo_pop, .fifo_valid, .fifo_data, .fifo_bytes, .prefetchfifo_used
    );

endmodule

// ==== design/prefetch.sv ====
`timescale 1ns/1ps

module prefetch (
    input  logic        clk,
    input  logic        rst,
    input  logic        pr_reset,
    input  logic [31:0] branch_address,
    input  logic [31:0] fetch_limit,
    input  logic        branch_su,
    input  logic        push_do,
    input  logic [2:0]  push_bytes,
    output logic [31:0] prefetch_address,
    output logic [4:0]  prefetch_length,
    output logic        prefetch_su
);
    import fetch_pkg::*;

    // Bytes still allowed up to and including the limit
    // Wide enough for a full 4 GiB window
    logic [32:0] bytes_left;

    // ----------------------------------------
    // Address, remaining window, privilege
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            prefetch_address <= '0;
            bytes_left       <= '0;
            prefetch_su      <= 1'b0;
        end else if (pr_reset) begin
            // Branch reloads everything
            prefetch_address <= branch_address;
            prefetch_su      <= branch_su;
            if (fetch_limit >= branch_address) begin
                bytes_left <= {1'b0, fetch_limit} - {1'b0, branch_address} + 33'd1;
            end else begin
                // Target already past the limit
                bytes_left <= '0;
            end
        end else if (push_do) begin
            // Advance by what the reader handed to the queue
            prefetch_address <= prefetch_address + {29'd0, push_bytes};
            bytes_left       <= bytes_left - {30'd0, push_bytes};
        end
    end

    // Clamp to one read request
    always_comb begin
        if (bytes_left > 33'(MAX_FETCH_LEN)) begin
            prefetch_length = 5'(MAX_FETCH_LEN);
        end else begin
            prefetch_length = bytes_left[4:0];
        end
    end

endmodule

// ==== design/prefetch_control.sv ====
`timescale 1ns/1ps

module prefetch_control (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pr_reset,
    input  logic [31:0]                          prefetch_address,
    input  logic [4:0]                           prefetch_length,
    input  logic                                 prefetch_su,
    input  logic [$clog2(fetch_pkg::FIFO_DEPTH):0] prefetchfifo_used,
    output logic                                 tlbcoderequest_do,
    output logic [31:0]                          tlbcoderequest_address,
    output logic                                 tlbcoderequest_su,
    input  logic                                 tlbcode_do,
    input  logic [31:0]                          tlbcode_linear,
    input  logic [31:0]                          tlbcode_physical,
    output logic                                 icacheread_do,
    output logic [31:0]                          icacheread_address,
    output logic [4:0]                           icacheread_length
);
    import fetch_pkg::*;

    logic  state;
    // Last translated pair
    addr_u linear;
    addr_u physical;
    addr_u pf;
    addr_u merged;

    logic [OFFSET_BITS:0] left_in_page;
    logic [4:0]           length;
    logic                 page_cross;
    logic                 queue_full;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign pf.flat = prefetch_address;

    assign tlbcoderequest_address = prefetch_address;
    assign tlbcoderequest_su      = prefetch_su;

    // Never read past the end of the page
    assign left_in_page = 13'd4096 - {1'b0, pf.split.offset};
    assign length = (left_in_page < {8'd0, prefetch_length}) ? left_in_page[4:0]
                                                             : prefetch_length;

    assign page_cross    = pf.split.page != linear.split.page;
    assign queue_full    = prefetchfifo_used >= 5'(FIFO_STOP_LEVEL);

    // Saved physical page with the current fetch offset
    assign merged.split.page   = physical.split.page;
    assign merged.split.offset = pf.split.offset;

    // ----------------------------------------
    // Request outputs
    // ----------------------------------------
    always_comb begin
        tlbcoderequest_do  = 1'b0;
        icacheread_do      = 1'b0;
        icacheread_address = merged.flat;
        icacheread_length  = length;
        if (state == CTRL_TLB) begin
            // Translate only when the queue runs low
            if (!pr_reset && prefetch_length != 5'd0 &&
                prefetchfifo_used < 5'(FIFO_START_LEVEL)) begin
                tlbcoderequest_do = 1'b1;
                if (tlbcode_do) begin
                    // Read goes out in the same cycle as the answer
                    icacheread_do      = 1'b1;
                    icacheread_address = tlbcode_physical;
                end
            end
        end else if (!page_cross && !pr_reset && !queue_full && length != 5'd0) begin
            icacheread_do = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CTRL_TLB;
        end else if (state == CTRL_TLB) begin
            if (tlbcoderequest_do && tlbcode_do) begin
                state <= CTRL_READ;
            end
        end else if (page_cross || pr_reset || queue_full) begin
            state <= CTRL_TLB;
        end
    end

    // Translation pair of the current page
    always_ff @(posedge clk) begin
        if (state == CTRL_TLB && tlbcoderequest_do && tlbcode_do) begin
            linear.flat   <= tlbcode_linear;
            physical.flat <= tlbcode_physical;
        end
    end

endmodule

// ==== design/prefetch_fifo.sv ====
`timescale 1ns/1ps

module prefetch_fifo (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   pr_reset,
    input  logic                                   push_do,
    input  logic [31:0]                            push_data,
    input  logic [2:0]                             push_bytes,
    input  logic                                   fifo_pop,
    output logic                                   fifo_valid,
    output logic [31:0]                            fifo_data,
    output logic [2:0]                             fifo_bytes,
    output logic [$clog2(fetch_pkg::FIFO_DEPTH):0] prefetchfifo_used
);
    import fetch_pkg::*;

    logic [31:0] data_mem  [FIFO_DEPTH];
    logic [2:0]  bytes_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic                          pop;

    // Head entry straight from storage
    assign fifo_valid = prefetchfifo_used != '0;
    assign fifo_data  = data_mem[rd_ptr];
    assign fifo_bytes = bytes_mem[rd_ptr];
    assign pop        = fifo_pop && fifo_valid;

    // Pointers wrap on their own width
    always_ff @(posedge clk) begin
        if (rst || pr_reset) begin
            wr_ptr            <= '0;
            rd_ptr            <= '0;
            prefetchfifo_used <= '0;
        end else begin
            wr_ptr            <= wr_ptr + {3'd0, push_do};
            rd_ptr            <= rd_ptr + {3'd0, pop};
            prefetchfifo_used <= prefetchfifo_used + {4'd0, push_do} - {4'd0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push_do) begin
            data_mem[wr_ptr]  <= push_data;
            bytes_mem[wr_ptr] <= push_bytes;
        end
    end

endmodule

// ==== fetch_unit.f ====
design/fetch_pkg.sv
design/prefetch.sv
design/prefetch_control.sv
design/code_tlb.sv
design/code_reader.sv
design/prefetch_fifo.sv
design/fetch_unit.sv
bench/fetch_unit_tb.sv
